// ==== src/core_pkg.sv ====
// shared widths and encodings of the execute slice; widths are fixed by the instruction format
package core_pkg;

    // data path width
    localparam int xlen = 32;

    // register index width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // lanes per issued pair
    localparam int num_lanes = 2;

    // alu opcodes
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        // signed compare
        alu_slt = 3'd7
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // second operand source
    typedef enum logic [1:0] {
        src2_rf     = 2'd0,
        src2_imm    = 2'd1,
        // stable counter halves
        src2_cnt_lo = 2'd2,
        src2_cnt_hi = 2'd3
    } src2_sel_e;

    // four-phase intake handshake
    typedef enum logic [1:0] {
        issue_idle         = 2'd0,
        // pair just taken, valid shown for this cycle
        issue_acked        = 2'd1,
        // ack held until req drops
        issue_wait_release = 2'd2
    } issue_state_e;

endpackage

// ==== src/issue_stage.sv ====
// one pair per four-phase req/ack handshake; req must stay low until ack has dropped
`timescale 1ns/100ps
module issue_stage (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              flush,
    input  logic                              req,
    input  logic                              in_valid [core_pkg::num_lanes],
    input  core_pkg::alu_op_e                 in_op    [core_pkg::num_lanes],
    input  core_pkg::src1_sel_e               in_src1  [core_pkg::num_lanes],
    input  core_pkg::src2_sel_e               in_src2  [core_pkg::num_lanes],
    input  logic                              in_wb    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rd    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rj    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rk    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         in_pc    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         in_imm   [core_pkg::num_lanes],
    output logic                              ack,
    output logic                              out_valid [core_pkg::num_lanes],
    output core_pkg::alu_op_e                 out_op    [core_pkg::num_lanes],
    output core_pkg::src1_sel_e               out_src1  [core_pkg::num_lanes],
    output core_pkg::src2_sel_e               out_src2  [core_pkg::num_lanes],
    output logic                              out_wb    [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   out_rd    [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   out_rj    [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   out_rk    [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         out_pc    [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         out_imm   [core_pkg::num_lanes],
    output logic [63:0]                       cnt
);

    core_pkg::issue_state_e state;
    logic                   capture;

    // first edge seeing req in idle takes the pair
    assign capture = (state == core_pkg::issue_idle) && req;
    assign ack     = (state != core_pkg::issue_idle);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= core_pkg::issue_idle;
        end else begin
            case (state)
                core_pkg::issue_idle: begin
                    if (req) begin
                        state <= core_pkg::issue_acked;
                    end
                end
                core_pkg::issue_acked,
                core_pkg::issue_wait_release: begin
                    if (!req) begin
                        state <= core_pkg::issue_idle;
                    end else begin
                        state <= core_pkg::issue_wait_release;
                    end
                end
                default: state <= core_pkg::issue_idle;
            endcase
        end
    end

    // valid is a one cycle pulse per accepted pair
    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            if (!rstn) begin
                out_valid[i] <= 1'b0;
            end else begin
                out_valid[i] <= capture && in_valid[i] && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            if (capture) begin
                out_op[i]   <= in_op[i];
                out_src1[i] <= in_src1[i];
                out_src2[i] <= in_src2[i];
                out_wb[i]   <= in_wb[i];
                out_rd[i]   <= in_rd[i];
                out_rj[i]   <= in_rj[i];
                out_rk[i]   <= in_rk[i];
                out_pc[i]   <= in_pc[i];
                out_imm[i]  <= in_imm[i];
            end
        end
    end

    // stable counter, free running
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 64'd1;
        end
    end

endmodule

// ==== src/register_file.sv ====
// 32x32 register file with write bypass; no forwarding between lanes of one pair
`timescale 1ns/100ps
module register_file (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              flush,
    input  logic                              iss_valid [core_pkg::num_lanes],
    input  core_pkg::alu_op_e                 iss_op    [core_pkg::num_lanes],
    input  core_pkg::src1_sel_e               iss_src1  [core_pkg::num_lanes],
    input  core_pkg::src2_sel_e               iss_src2  [core_pkg::num_lanes],
    input  logic                              iss_wb    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   iss_rd    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   iss_rj    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   iss_rk    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         iss_pc    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         iss_imm   [core_pkg::num_lanes],
    input  logic [63:0]                       cnt,
    input  logic                              wb_en     [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   wb_addr   [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         wb_data   [core_pkg::num_lanes],
    output logic                              rf_valid  [core_pkg::num_lanes],
    output core_pkg::alu_op_e                 rf_op     [core_pkg::num_lanes],
    output logic                              rf_wb     [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   rf_rd     [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         opa       [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         opb       [core_pkg::num_lanes]
);

    logic [core_pkg::xlen-1:0] regs     [2**core_pkg::reg_addr_w];
    logic [core_pkg::xlen-1:0] opa_next [core_pkg::num_lanes];
    logic [core_pkg::xlen-1:0] opb_next [core_pkg::num_lanes];

    // r0 reads zero, then bypass, then array
    function automatic logic [core_pkg::xlen-1:0] read_reg(
        input logic [core_pkg::reg_addr_w-1:0] addr
    );
        logic [core_pkg::xlen-1:0] value;
        value = regs[addr];
        // lane 1 checked last so it overrides lane 0 on a shared target
        for (int p = 0; p < core_pkg::num_lanes; p++) begin
            if (wb_en[p] && (wb_addr[p] == addr)) begin
                value = wb_data[p];
            end
        end
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    // write ports, later lane wins on the same address
    always_ff @(posedge clk) begin
        for (int p = 0; p < core_pkg::num_lanes; p++) begin
            if (wb_en[p]) begin
                regs[wb_addr[p]] <= wb_data[p];
            end
        end
    end

    // operand select per lane
    always_comb begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            case (iss_src1[i])
                core_pkg::src1_rf: begin
                    opa_next[i] = read_reg(iss_rj[i]);
                end
                core_pkg::src1_pc: begin
                    opa_next[i] = iss_pc[i];
                end
                default: begin
                    opa_next[i] = '0;
                end
            endcase

            case (iss_src2[i])
                core_pkg::src2_rf: begin
                    opb_next[i] = read_reg(iss_rk[i]);
                end
                core_pkg::src2_imm: begin
                    opb_next[i] = iss_imm[i];
                end
                core_pkg::src2_cnt_lo: begin
                    opb_next[i] = cnt[31:0];
                end
                default: begin
                    opb_next[i] = cnt[63:32];
                end
            endcase
        end
    end

    // stage register, valid only is cleared
    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            if (!rstn) begin
                rf_valid[i] <= 1'b0;
            end else begin
                rf_valid[i] <= iss_valid[i] && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            rf_op[i] <= iss_op[i];
            rf_wb[i] <= iss_wb[i];
            rf_rd[i] <= iss_rd[i];
            opa[i]   <= opa_next[i];
            opb[i]   <= opb_next[i];
        end
    end

endmodule

// ==== src/exec_stage.sv ====
// two single-cycle ALUs with registered writeback; shifts take the low 5 bits of opb
`timescale 1ns/100ps
module exec_stage (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              flush,
    input  logic                              rf_valid [core_pkg::num_lanes],
    input  core_pkg::alu_op_e                 rf_op    [core_pkg::num_lanes],
    input  logic                              rf_wb    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   rf_rd    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         opa      [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         opb      [core_pkg::num_lanes],
    output logic                              wb_en    [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   wb_addr  [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         wb_data  [core_pkg::num_lanes]
);

    localparam int shamt_w = $clog2(core_pkg::xlen);

    function automatic logic [core_pkg::xlen-1:0] alu(
        input core_pkg::alu_op_e          op,
        input logic [core_pkg::xlen-1:0]  a,
        input logic [core_pkg::xlen-1:0]  b
    );
        logic [shamt_w-1:0]        shamt;
        logic [core_pkg::xlen-1:0] result;
        shamt = b[shamt_w-1:0];
        case (op)
            core_pkg::alu_add: begin
                result = a + b;
            end
            core_pkg::alu_sub: begin
                result = a - b;
            end
            core_pkg::alu_and: begin
                result = a & b;
            end
            core_pkg::alu_or: begin
                result = a | b;
            end
            core_pkg::alu_xor: begin
                result = a ^ b;
            end
            core_pkg::alu_sll: begin
                result = a << shamt;
            end
            core_pkg::alu_srl: begin
                result = a >> shamt;
            end
            default: begin
                // slt, signed
                result = {{(core_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
        endcase
        return result;
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            if (!rstn) begin
                wb_en[i] <= 1'b0;
            end else begin
                wb_en[i] <= rf_valid[i] && rf_wb[i] && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::num_lanes; i++) begin
            wb_addr[i] <= rf_rd[i];
            wb_data[i] <= alu(rf_op[i], opa[i], opb[i]);
        end
    end

endmodule

// ==== src/dual_issue_core.sv ====
// two-lane execute slice; results leave on wb_* two edges after ack rises
`timescale 1ns/100ps
module dual_issue_core (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              flush,
    input  logic                              req,
    input  logic                              in_valid [core_pkg::num_lanes],
    input  core_pkg::alu_op_e                 in_op    [core_pkg::num_lanes],
    input  core_pkg::src1_sel_e               in_src1  [core_pkg::num_lanes],
    input  core_pkg::src2_sel_e               in_src2  [core_pkg::num_lanes],
    input  logic                              in_wb    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rd    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rj    [core_pkg::num_lanes],
    input  logic [core_pkg::reg_addr_w-1:0]   in_rk    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         in_pc    [core_pkg::num_lanes],
    input  logic [core_pkg::xlen-1:0]         in_imm   [core_pkg::num_lanes],
    output logic                              ack,
    output logic                              wb_en    [core_pkg::num_lanes],
    output logic [core_pkg::reg_addr_w-1:0]   wb_addr  [core_pkg::num_lanes],
    output logic [core_pkg::xlen-1:0]         wb_data  [core_pkg::num_lanes]
);

    // issue to register read
    logic                            iss_valid [core_pkg::num_lanes];
    core_pkg::alu_op_e               iss_op    [core_pkg::num_lanes];
    core_pkg::src1_sel_e             iss_src1  [core_pkg::num_lanes];
    core_pkg::src2_sel_e             iss_src2  [core_pkg::num_lanes];
    logic                            iss_wb    [core_pkg::num_lanes];
    logic [core_pkg::reg_addr_w-1:0] iss_rd    [core_pkg::num_lanes];
    logic [core_pkg::reg_addr_w-1:0] iss_rj    [core_pkg::num_lanes];
    logic [core_pkg::reg_addr_w-1:0] iss_rk    [core_pkg::num_lanes];
    logic [core_pkg::xlen-1:0]       iss_pc    [core_pkg::num_lanes];
    logic [core_pkg::xlen-1:0]       iss_imm   [core_pkg::num_lanes];
    logic [63:0]                     cnt;

    // register read to execute
    logic                            rf_valid  [core_pkg::num_lanes];
    core_pkg::alu_op_e               rf_op     [core_pkg::num_lanes];
    logic                            rf_wb     [core_pkg::num_lanes];
    logic [core_pkg::reg_addr_w-1:0] rf_rd     [core_pkg::num_lanes];
    logic [core_pkg::xlen-1:0]       opa       [core_pkg::num_lanes];
    logic [core_pkg::xlen-1:0]       opb       [core_pkg::num_lanes];

    issue_stage i_issue_stage (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .req       (req),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_wb     (in_wb),
        .in_rd     (in_rd),
        .in_rj     (in_rj),
        .in_rk     (in_rk),
        .in_pc     (in_pc),
        .in_imm    (in_imm),
        .ack       (ack),
        .out_valid (iss_valid),
        .out_op    (iss_op),
        .out_src1  (iss_src1),
        .out_src2  (iss_src2),
        .out_wb    (iss_wb),
        .out_rd    (iss_rd),
        .out_rj    (iss_rj),
        .out_rk    (iss_rk),
        .out_pc    (iss_pc),
        .out_imm   (iss_imm),
        .cnt       (cnt)
    );

    register_file i_register_file (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_src1  (iss_src1),
        .iss_src2  (iss_src2),
        .iss_wb    (iss_wb),
        .iss_rd    (iss_rd),
        .iss_rj    (iss_rj),
        .iss_rk    (iss_rk),
        .iss_pc    (iss_pc),
        .iss_imm   (iss_imm),
        .cnt       (cnt),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rf_valid  (rf_valid),
        .rf_op     (rf_op),
        .rf_wb     (rf_wb),
        .rf_rd     (rf_rd),
        .opa       (opa),
        .opb       (opb)
    );

    // writeback feeds the register file write ports
    exec_stage i_exec_stage (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .rf_valid  (rf_valid),
        .rf_op     (rf_op),
        .rf_wb     (rf_wb),
        .rf_rd     (rf_rd),
        .opa       (opa),
        .opb       (opb),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

endmodule

// ==== dv/dual_issue_core_props.sv ====
// handshake and writeback properties on clk; all but the reset check are off while rstn is low
`timescale 1ns/100ps
module dual_issue_core_props (
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic req,
    input logic ack,
    input logic wb_en [core_pkg::num_lanes]
);

    // ack only answers a pending req
    ack_rise_with_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_fall_after_release: assert property (@(posedge clk) disable iff (!rstn)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    wb_quiet_after_reset: assert property (@(posedge clk)
        !rstn |=> (!wb_en[0] && !wb_en[1]))
        else $error("writeback enabled on the edge after reset");

    // anything in flight is dropped
    wb_quiet_after_flush: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> (!wb_en[0] && !wb_en[1]))
        else $error("writeback enabled on the edge after flush");

endmodule

bind dual_issue_core dual_issue_core_props i_dual_issue_core_props (
    .clk   (clk),
    .rstn  (rstn),
    .flush (flush),
    .req   (req),
    .ack   (ack),
    .wb_en (wb_en)
);

// ==== dv/tb_dual_issue_core.sv ====
// model treats cnt_hi as zero, so runs must stay well under 2**32 cycles; counter lanes write r0
`timescale 1ns/100ps
module tb_dual_issue_core;

    localparam int total_pairs = 36;
    localparam int period = 20;

    typedef struct packed {
        logic        lane;
        logic        rng;
        logic [4:0]  addr;
        logic [31:0] val;
    } exp_t;

    logic                clk = 1'b0;
    logic                rstn;
    logic                flush;
    logic                req;
    logic                ack;
    logic                in_valid [2];
    core_pkg::alu_op_e   in_op    [2];
    core_pkg::src1_sel_e in_src1  [2];
    core_pkg::src2_sel_e in_src2  [2];
    logic                in_wb    [2];
    logic [4:0]          in_rd    [2];
    logic [4:0]          in_rj    [2];
    logic [4:0]          in_rk    [2];
    logic [31:0]         in_pc    [2];
    logic [31:0]         in_imm   [2];
    logic                wb_en    [2];
    logic [4:0]          wb_addr  [2];
    logic [31:0]         wb_data  [2];

    logic [31:0] model_regs [32];
    exp_t        exp_q [$];
    logic [31:0] cycle;
    logic [31:0] last_cnt = 32'd0;
    integer      seed = 25;
    int          checks = 0;
    int          errors = 0;
    int          pairs = 0;
    int          req_hold = 0;

    dual_issue_core i_dual_issue_core (.*);

    always #(period / 2) clk = ~clk;

    // mirrors the stable counter
    always @(posedge clk) begin
        if (!rstn) begin
            cycle <= 32'd0;
        end else begin
            cycle <= cycle + 32'd1;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return 5'(r % 32'd31) + 5'd1;
    endfunction

    function automatic logic [31:0] ref_alu(input core_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            core_pkg::alu_add: return a + b;
            core_pkg::alu_sub: return a - b;
            core_pkg::alu_and: return a & b;
            core_pkg::alu_or:  return a | b;
            core_pkg::alu_xor: return a ^ b;
            core_pkg::alu_sll: return a << b[4:0];
            core_pkg::alu_srl: return a >> b[4:0];
            default:           return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic set_lane(input int l, input core_pkg::alu_op_e op,
                            input core_pkg::src1_sel_e s1, input core_pkg::src2_sel_e s2,
                            input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk,
                            input logic [31:0] imm);
        in_valid[l] = 1'b1;
        in_wb[l]    = 1'b1;
        in_op[l]    = op;
        in_src1[l]  = s1;
        in_src2[l]  = s2;
        in_rd[l]    = rd;
        in_rj[l]    = rj;
        in_rk[l]    = rk;
        in_imm[l]   = imm;
        in_pc[l]    = 32'h0000_1000 + 32'(pairs * 8 + l * 4);
    endtask

    task automatic reg_op(input int l, input core_pkg::alu_op_e op,
                          input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk);
        set_lane(l, op, core_pkg::src1_rf, core_pkg::src2_rf, rd, rj, rk, 32'd0);
    endtask

    task automatic move_imm(input int l, input logic [4:0] rd, input logic [31:0] imm);
        set_lane(l, core_pkg::alu_add, core_pkg::src1_zero, core_pkg::src2_imm,
                 rd, 5'd0, 5'd0, imm);
    endtask

    task automatic read_back(input int l, input logic [4:0] rd, input logic [4:0] rj);
        set_lane(l, core_pkg::alu_add, core_pkg::src1_rf, core_pkg::src2_imm, rd, rj, 5'd0, 32'd0);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_ack(input logic level);
        do begin
            @(posedge clk);
            #2;
        end while (ack !== level);
    endtask

    // model update, then one four-phase handshake
    task automatic send_pair(input logic keep, input logic kill);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res [2];
        exp_t        e;
        for (int l = 0; l < 2; l++) begin
            case (in_src1[l])
                core_pkg::src1_rf: a = model_regs[in_rj[l]];
                core_pkg::src1_pc: a = in_pc[l];
                default:           a = 32'd0;
            endcase
            case (in_src2[l])
                core_pkg::src2_rf:  b = model_regs[in_rk[l]];
                core_pkg::src2_imm: b = in_imm[l];
                default:            b = 32'd0;
            endcase
            res[l] = ref_alu(in_op[l], a, b);
            if (keep) begin
                e.lane = 1'(l);
                e.rng  = (in_src2[l] == core_pkg::src2_cnt_lo);
                e.addr = in_rd[l];
                e.val  = e.rng ? cycle : res[l];
                exp_q.push_back(e);
            end
        end
        // both lanes saw the old state, lane 1 lands last
        for (int l = 0; l < 2; l++) begin
            if (keep) begin
                model_regs[in_rd[l]] = res[l];
            end
        end
        model_regs[0] = 32'd0;
        req   = 1'b1;
        flush = kill;
        wait_ack(1'b1);
        if (req_hold > 0) begin
            idle(req_hold);
            check(32'(ack), 32'd1, "ack held while req is high");
        end
        req   = 1'b0;
        flush = 1'b0;
        wait_ack(1'b0);
        pairs++;
    endtask

    task automatic check_result(input int lane);
        exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected writeback on lane %0d at time %0t", lane, $time);
        end else begin
            e = exp_q.pop_front();
            check(32'(lane), 32'(e.lane), "writeback lane order");
            check(32'(wb_addr[lane]), 32'(e.addr), "writeback address");
            if (e.rng) begin
                check(32'(wb_data[lane] >= e.val && wb_data[lane] <= cycle), 32'd1,
                      "cnt_lo window");
                check(32'(wb_data[lane] > last_cnt), 32'd1, "cnt_lo increasing");
                last_cnt = wb_data[lane];
            end else begin
                check(wb_data[lane], e.val, "writeback data");
            end
        end
    endtask

    // collector
    always @(negedge clk) begin
        if (rstn) begin
            for (int l = 0; l < 2; l++) begin
                if (wb_en[l]) begin
                    check_result(l);
                end
            end
        end
    end

    task automatic fill_registers();
        for (int k = 0; k < 16; k++) begin
            // r1..r31, the last slot wraps to r0
            move_imm(0, 5'(2 * k + 1), rand_word());
            move_imm(1, 5'(2 * k + 2), rand_word());
            send_pair(1'b1, 1'b0);
        end
    endtask

    task automatic alu_ops();
        logic [4:0] rd [2];
        for (int p = 0; p < 4; p++) begin
            for (int l = 0; l < 2; l++) begin
                rd[l] = pick_reg();
                reg_op(l, core_pkg::alu_op_e'(3'(2 * p + l)), rd[l], pick_reg(), pick_reg());
            end
            send_pair(1'b1, 1'b0);
            read_back(0, rd[0], rd[0]);
            read_back(1, rd[1], rd[1]);
            send_pair(1'b1, 1'b0);
        end
    endtask

    task automatic operand_selects();
        set_lane(0, core_pkg::alu_add, core_pkg::src1_pc, core_pkg::src2_imm,
                 5'd24, 5'd0, 5'd0, 32'h0000_0100);
        set_lane(1, core_pkg::alu_or, core_pkg::src1_zero, core_pkg::src2_rf,
                 5'd25, 5'd0, 5'd0, 32'd0);
        send_pair(1'b1, 1'b0);
        set_lane(0, core_pkg::alu_add, core_pkg::src1_zero, core_pkg::src2_cnt_hi,
                 5'd0, 5'd0, 5'd0, 32'd0);
        set_lane(1, core_pkg::alu_add, core_pkg::src1_zero, core_pkg::src2_cnt_lo,
                 5'd0, 5'd0, 5'd0, 32'd0);
        send_pair(1'b1, 1'b0);
        idle(3);
        reg_op(0, core_pkg::alu_add, 5'd26, 5'd0, 5'd0);
        send_pair(1'b1, 1'b0);
    endtask

    task automatic dependent_chain();
        reg_op(0, core_pkg::alu_add, 5'd5, 5'd1, 5'd2);
        reg_op(1, core_pkg::alu_xor, 5'd6, 5'd3, 5'd4);
        send_pair(1'b1, 1'b0);
        reg_op(0, core_pkg::alu_sub, 5'd7, 5'd5, 5'd6);
        reg_op(1, core_pkg::alu_slt, 5'd8, 5'd6, 5'd5);
        send_pair(1'b1, 1'b0);
        // r10 sees r9 from before this pair
        reg_op(0, core_pkg::alu_add, 5'd9, 5'd7, 5'd8);
        reg_op(1, core_pkg::alu_or, 5'd10, 5'd9, 5'd7);
        send_pair(1'b1, 1'b0);
    endtask

    task automatic same_target();
        move_imm(0, 5'd12, 32'h1111_0000);
        move_imm(1, 5'd12, 32'h2222_0000);
        send_pair(1'b1, 1'b0);
        read_back(0, 5'd13, 5'd12);
        read_back(1, 5'd14, 5'd13);
        send_pair(1'b1, 1'b0);
        // array path this time
        idle(4);
        read_back(0, 5'd15, 5'd12);
        read_back(1, 5'd16, 5'd14);
        // slow source, ack has to wait for the release
        req_hold = 2;
        send_pair(1'b1, 1'b0);
        req_hold = 0;
    endtask

    task automatic flush_in_flight();
        idle(4);
        move_imm(0, 5'd20, 32'hdead_0020);
        move_imm(1, 5'd22, 32'hdead_0022);
        send_pair(1'b0, 1'b0);
        move_imm(0, 5'd21, 32'hdead_0021);
        move_imm(1, 5'd23, 32'hdead_0023);
        send_pair(1'b0, 1'b1);
        read_back(0, 5'd20, 5'd20);
        read_back(1, 5'd23, 5'd23);
        send_pair(1'b1, 1'b0);
    endtask

    initial begin
        rstn  = 1'b0;
        flush = 1'b0;
        req   = 1'b0;
        move_imm(0, 5'd0, 32'd0);
        move_imm(1, 5'd0, 32'd0);
        in_valid[0] = 1'b0;
        in_valid[1] = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        fill_registers();
        alu_ops();
        operand_selects();
        dependent_chain();
        same_target();
        flush_in_flight();
        idle(4);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(4);
        $display("pairs %0d, checks %0d, errors %0d", pairs, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(period * (total_pairs * 10 + 100));
        $display("timeout: the run did not finish within %0d cycles", total_pairs * 10 + 100);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== src.f ====
src/core_pkg.sv
src/issue_stage.sv
src/register_file.sv
src/exec_stage.sv
src/dual_issue_core.sv
dv/dual_issue_core_props.sv
dv/tb_dual_issue_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dual_issue_core -f src.f \
    -o tb_dual_issue_core
./obj_dir/tb_dual_issue_core > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
